/* bench/golden_cycles.txt */
# kind(0 fetch 1 mrd 2 mwr 3 iord 4 iowr 5 intack 7 busrq) addr wrdata waits readdata
# For kind 7 the waits column is the number of cycles BUSRQ is held
0 0110 00 0 3e
1 2021 00 0 a7
2 3032 5c 0 00
3 0043 00 0 19
4 0054 c4 0 00
5 0065 00 0 ff
0 0176 00 2 21
1 4087 00 1 6b
7 0000 00 12 00
2 5098 e1 3 00
3 01a9 00 1 b4
4 02ba 7f 2 00
5 00cb 00 1 c7
0 12dc 00 0 d9
1 00ed 00 0 4e
0 00fe 00 0 80

/* bench/z80BusUnitTb.sv */
// Testbench for the bus-cycle engine, stimulus and expected values from the golden file
// Models memory, IO, WAIT, the bus master and a credit-granting consumer
`timescale 1ns/1ps
`default_nettype none

module z80BusUnitTb;
    localparam int REQ_DEPTH = 4;
    localparam int RES_DEPTH = 2;
    localparam int TMO = 400;  // Cycles allowed per wait loop
    localparam int STALL_RELEASE = 40;  // Credit stall long enough to show back-pressure

    logic lastT = 1'b0, rstN = 1'b0;
    logic reqValid = 1'b0, resCredit = 1'b0, waitPin = 1'b0, busrqPin = 1'b0;
    z80BusPkg::cycleKindT reqKind = z80BusPkg::kFetch, resKind;
    logic [15:0] reqAddr = '0, addrPins;
    logic [7:0] reqWrData = '0, dataIn = '0, resData, dataOut;
    logic reqCredit, resValid, m1, mreq, iorq, rd, wr, rfsh, busack;
    logic addrPinOe, dataOutOe, ctlPinOe;

    int lKind[64], lAddr[64], lWd[64], lWait[64], lExp[64];
    int reqLine[64], readExp[64], readKind[64];
    int nLines = 0, nReqs = 0, nReads = 0;
    int sent = 0, creditsBack = 0, started = 0, seen = 0, granted = 0;
    int curLine, strobeCnt, cycLen, waitLeft = 0;
    bit open = 0, withhold = 1;
    logic [7:0] mem[256];
    integer seed = 23739;

    z80BusUnit #(.REQ_DEPTH(REQ_DEPTH), .RES_DEPTH(RES_DEPTH)) DUT (.*);

    always #2 lastT = !lastT;

    task automatic check(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("ERR %s expected %0h actual %0h", name, exp, act);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic timeoutFail(input string what);
        $display("Timed out waiting for %s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    // Strobe cycles per kind from the pin windows, plus 2 per Tw
    function automatic int windowLen(input int kind, input int waits);
        int base;
        case (kind)
            1, 2:    base = 4;
            5:       base = 6;
            default: base = 5;  // Fetch and IO
        endcase
        return base + 2 * waits;
    endfunction

    // lastT cycles per machine cycle, two per T-state and two per Tw
    function automatic int cycleLen(input int kind, input int waits);
        int tStates;
        case (kind)
            1, 2:    tStates = 3;
            5:       tStates = 6;
            default: tStates = 4;  // Fetch and IO
        endcase
        return 2 * (tStates + waits);
    endfunction

    function automatic int waitSampleT(input int kind);
        if (kind == 3 || kind == 4) return 3;
        return (kind == 5) ? 4 : 2;
    endfunction

    // --------------------
    // Bus model and cycle monitor
    always @(posedge lastT) begin
        if (rstN) begin
            if (reqCredit) creditsBack++;
            if (busack) check("strobes while bus granted", 0, int'(mreq | iorq | rd | wr));
            if (open) begin
                if (DUT.uSequencer.tState != 3'd0) cycLen++;
                if (mreq || iorq) strobeCnt++;
                if (m1) check("m1 kind", 1, int'(lKind[curLine] == 0 || lKind[curLine] == 5));
                if (rfsh) check("rfsh window", 1,
                                int'((lKind[curLine] == 0 || lKind[curLine] == 5) &&
                                     cycLen > cycleLen(lKind[curLine], lWait[curLine]) - 4));
                if (wr) begin  // Write capture
                    check("write addr", lAddr[curLine], int'(addrPins));
                    check("write data", lWd[curLine], int'(dataOut));
                    check("write data oe", 1, int'(dataOutOe));
                end
                if (waitPin && DUT.uSequencer.phaseLow &&
                    DUT.uSequencer.tState == 3'(waitSampleT(lKind[curLine])))
                    waitLeft--;
            end
            if (open && (DUT.headTake || DUT.uSequencer.tState == 3'd0)) begin
                check("strobe window", windowLen(lKind[curLine], lWait[curLine]), strobeCnt);
                check("cycle length", cycleLen(lKind[curLine], lWait[curLine]), cycLen);
                open = 0;
            end
            if (DUT.headTake) begin
                curLine = reqLine[started];
                started++;
                strobeCnt = 0;
                cycLen = 0;
                waitLeft = lWait[curLine];
                open = 1;
            end
            if (resValid) begin
                check("credit held at resValid", 1, int'(granted > seen));
                check("result kind", readKind[seen], int'(resKind));
                check("result data", readExp[seen], int'(resData));
                seen++;
            end
        end
        #1;
        waitPin = (waitLeft > 0);
        dataIn = mem[addrPins[7:0]];
    end

    // Consumer grants credits after a withheld stretch, spaced at random
    always @(posedge lastT) begin
        #1;
        resCredit = 1'b0;
        if (!withhold && (granted - seen) < RES_DEPTH && ($random(seed) & 3) == 0) begin
            resCredit = 1'b1;
            granted++;
        end
    end

    initial begin
        int fd, k;
        string line;
        for (int i = 0; i < 256; i++) mem[i] = 8'(i * 37 + 11);
        fd = $fopen("bench/golden_cycles.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the golden file");
            $display("Checks failed");
            $fatal(1);
        end
        while ($fgets(line, fd)) begin
            if (line.len() < 2 || line[0] == "#") continue;
            k = nLines;
            void'($sscanf(line, "%d %h %h %d %h", lKind[k], lAddr[k], lWd[k], lWait[k], lExp[k]));
            if (lKind[k] != 7) begin
                reqLine[nReqs] = k;
                nReqs++;
                if (lKind[k] != 2 && lKind[k] != 4) begin
                    mem[lAddr[k] & 8'hff] = 8'(lExp[k]);  // Preload memory and IO
                    readExp[nReads] = lExp[k];
                    readKind[nReads] = lKind[k];
                    nReads++;
                end
            end
            nLines++;
        end
        $fclose(fd);

        repeat (2) @(posedge lastT);
        #1 rstN = 1'b1;
        check("reset busack", 0, int'(busack));
        check("reset strobes", 0, int'(m1 | mreq | iorq | rd | wr | rfsh));
        check("reset pad oe", 1, int'(addrPinOe & ctlPinOe));
        check("reset resValid", 0, int'(resValid | reqCredit));

        for (int i = 0; i < nLines; i++) begin
            if (lKind[i] == 7) begin
                @(posedge lastT);
                #1 busrqPin = 1'b1;
                k = 0;
                while (!busack) begin
                    @(posedge lastT);
                    k++;
                    if (k > TMO) timeoutFail("busack to rise");
                end
                check("addr oe in grant", 0, int'(addrPinOe));
                check("ctl oe in grant", 0, int'(ctlPinOe));
                repeat (lWait[i]) @(posedge lastT);
                #1 busrqPin = 1'b0;
                k = 0;
                while (busack) begin
                    @(posedge lastT);
                    k++;
                    if (k > TMO) timeoutFail("busack to fall");
                end
                continue;
            end
            k = 0;
            while (REQ_DEPTH - sent + creditsBack <= 0) begin
                @(posedge lastT);
                k++;
                if (k == STALL_RELEASE) withhold = 0;  // Queue backed up behind held results
                if (k > TMO) timeoutFail("a request credit");
            end
            @(posedge lastT);
            #1;
            reqValid = 1'b1;
            reqKind = z80BusPkg::cycleKindT'(lKind[i]);
            reqAddr = 16'(lAddr[i]);
            reqWrData = 8'(lWd[i]);
            sent++;
            @(posedge lastT);
            #1 reqValid = 1'b0;
        end
        withhold = 0;

        k = 0;
        while (seen < nReads || creditsBack < nReqs || open) begin
            @(posedge lastT);
            k++;
            if (k > 4 * TMO) timeoutFail("all cycles and results to finish");
        end
        check("credits returned", nReqs, creditsBack);
        check("cycles started", nReqs, started);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* design/cycleRequestQueue.sv */
// Request FIFO between the core and the T-state sequencer
// Each entry handed on returns one credit to the core
`timescale 1ns/1ps
`default_nettype none

module cycleRequestQueue #(
    parameter int REQ_DEPTH = 4
) (
    input  logic                         lastT,
    input  logic                         rstN,
    input  logic                         reqValid,
    input  z80BusPkg::cycleKindT         reqKind,
    input  logic [z80BusPkg::ADDR_W-1:0] reqAddr,
    input  logic [z80BusPkg::DATA_W-1:0] reqWrData,
    input  logic                         headTake,
    output logic                         headValid,
    output z80BusPkg::cycleKindT         headKind,
    output logic [z80BusPkg::ADDR_W-1:0] headAddr,
    output logic [z80BusPkg::DATA_W-1:0] headWrData,
    output logic                         reqCredit
);

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    z80BusPkg::cycleKindT         kindMem [REQ_DEPTH];
    logic [z80BusPkg::ADDR_W-1:0] addrMem [REQ_DEPTH];
    logic [z80BusPkg::DATA_W-1:0] dataMem [REQ_DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;  // Entries held

    // Circular pointer step, wraps at the depth
    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Storage
    always_ff @(posedge lastT) begin
        if (reqValid) begin
            kindMem[wrPtr] <= reqKind;
            addrMem[wrPtr] <= reqAddr;
            dataMem[wrPtr] <= reqWrData;
        end
    end

    always_ff @(posedge lastT or negedge rstN) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            count     <= '0;
            reqCredit <= 1'b0;
        end else begin
            if (reqValid) wrPtr <= nextPtr(wrPtr);
            if (headTake) rdPtr <= nextPtr(rdPtr);
            count     <= count + CNT_W'(reqValid) - CNT_W'(headTake);
            reqCredit <= headTake;  // Slot freed, core may send again
        end
    end

    assign headValid  = (count != '0);
    assign headKind   = kindMem[rdPtr];
    assign headAddr   = addrMem[rdPtr];
    assign headWrData = dataMem[rdPtr];

    // A push into a full queue means the core spent a credit it never had
    assert property (@(posedge lastT) disable iff (!rstN)
        reqValid |-> (count != CNT_W'(REQ_DEPTH)));

    // Sequencer only takes an entry that is offered
    assert property (@(posedge lastT) disable iff (!rstN)
        headTake |-> headValid);

endmodule

`default_nettype wire

/* design/pinControl.sv */
// Per-kind decode of the bus strobes and the pad enables and latch controls
// The second half of each T-state is phaseLow, Tw keeps the strobes of the T-state before
`timescale 1ns/1ps
`default_nettype none

module pinControl (
    input  z80BusPkg::cycleKindT curKind,
    input  logic [2:0]           tState,
    input  logic                 phaseLow,
    input  logic                 waitState,
    input  logic                 busGranted,
    output logic                 m1,
    output logic                 mreq,
    output logic                 iorq,
    output logic                 rd,
    output logic                 wr,
    output logic                 rfsh,
    output logic                 busack,
    output logic                 addrPinOe,
    output logic                 ctlPinOe,
    output logic                 dataOutOe,
    output logic                 abWe,
    output logic                 dbWe,
    output logic                 dbPinRe
);

    logic fFetch, fMRead, fMWrite, fIoRead, fIoWrite, fIntAck;
    logic t1, t2, t3, t4, t5, t6;
    logic hi, lo;

    // Function decode
    assign fFetch   = (curKind == z80BusPkg::kFetch);
    assign fMRead   = (curKind == z80BusPkg::kMemRead);
    assign fMWrite  = (curKind == z80BusPkg::kMemWrite);
    assign fIoRead  = (curKind == z80BusPkg::kIoRead);
    assign fIoWrite = (curKind == z80BusPkg::kIoWrite);
    assign fIntAck  = (curKind == z80BusPkg::kIntAck);

    // One-hot T-states, all low while idle
    assign t1 = (tState == 3'd1);
    assign t2 = (tState == 3'd2);
    assign t3 = (tState == 3'd3);
    assign t4 = (tState == 3'd4);
    assign t5 = (tState == 3'd5);
    assign t6 = (tState == 3'd6);

    // Tw behaves as the low half of the sampling T-state
    assign lo = phaseLow | waitState;
    assign hi = !lo;

    // --------------------
    // Bus strobes
    assign m1   = (fFetch & (t1 | t2)) |
                  (fIntAck & (t1 | t2 | t3 | t4));

    assign mreq = (fFetch & ((t1 & lo) | t2 | (t3 & lo) | (t4 & hi))) |  // Read, then refresh
                  ((fMRead | fMWrite) & ((t1 & lo) | t2 | (t3 & hi))) |
                  (fIntAck & ((t5 & lo) | t6));

    assign iorq = ((fIoRead | fIoWrite) & (t2 | t3 | (t4 & hi))) |
                  (fIntAck & ((t3 & lo) | t4));  // Vector read

    assign rd   = (fFetch & ((t1 & lo) | t2)) |
                  (fMRead & ((t1 & lo) | t2 | (t3 & hi))) |
                  (fIoRead & (t2 | t3 | (t4 & hi)));

    assign wr   = (fMWrite & ((t2 & lo) | (t3 & hi))) |  // Data settles for half a T first
                  (fIoWrite & (t2 | t3 | (t4 & hi)));

    assign rfsh = (fFetch & (t3 | t4)) |
                  (fIntAck & (t5 | t6));

    // --------------------
    // Bus release and pad controls
    assign busack    = busGranted;
    assign addrPinOe = !busGranted;
    assign ctlPinOe  = !busGranted;

    // Address latch loads in the T1 high half and holds through refresh
    assign abWe = hi & t1;

    assign dataOutOe = (fMWrite & ((t1 & lo) | t2 | t3)) |
                       (fIoWrite & ((t1 & lo) | t2 | t3 | t4));

    assign dbWe = (fMWrite | fIoWrite) & t1 & hi;  // Write byte into the pad latch

    // Pin data latched at the edge closing the read window, after any Tw
    assign dbPinRe = hi & ((fFetch & t3) | (fMRead & t3) | (fIoRead & t4) | (fIntAck & t5));

    always_comb begin
        assert (!(rd && wr));
    end

endmodule

`default_nettype wire

/* design/readDataReturn.sv */
// Latches read data from the pins and returns it to the core
// Results leave only against credits granted by the consumer
`timescale 1ns/1ps
`default_nettype none

module readDataReturn #(
    parameter int RES_DEPTH = 2
) (
    input  logic                         lastT,
    input  logic                         rstN,
    input  z80BusPkg::cycleKindT         curKind,
    input  logic                         dbPinRe,
    input  logic [z80BusPkg::DATA_W-1:0] dataIn,
    input  logic                         resCredit,
    output logic                         resultSlotFree,
    output logic                         resValid,
    output z80BusPkg::cycleKindT         resKind,
    output logic [z80BusPkg::DATA_W-1:0] resData
);

    localparam int PTR_W = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
    localparam int CNT_W = $clog2(RES_DEPTH + 1);

    z80BusPkg::cycleKindT         padKind;  // Kind of the byte in the pad latch
    logic [z80BusPkg::DATA_W-1:0] padData;
    logic                         padFull;  // Latched, not yet buffered

    z80BusPkg::cycleKindT         kindBuf [RES_DEPTH];
    logic [z80BusPkg::DATA_W-1:0] dataBuf [RES_DEPTH];
    logic [PTR_W-1:0]             wrPtr, rdPtr;
    logic [CNT_W-1:0]             count;    // Buffered results
    logic [CNT_W-1:0]             credits;  // Consumer credits on hand
    logic                         send;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(RES_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign send = (count != '0) && (credits != '0);

    // Pad latch counts as taken so a new read never outruns the buffer
    assign resultSlotFree = ({1'b0, count} + (CNT_W + 1)'(padFull)) < (CNT_W + 1)'(RES_DEPTH);

    // Payload path
    always_ff @(posedge lastT) begin
        if (dbPinRe) begin
            padData <= dataIn;
            padKind <= curKind;
        end
        if (padFull) begin
            dataBuf[wrPtr] <= padData;
            kindBuf[wrPtr] <= padKind;
        end
        if (send) begin
            resData <= dataBuf[rdPtr];
            resKind <= kindBuf[rdPtr];
        end
    end

    always_ff @(posedge lastT or negedge rstN) begin
        if (!rstN) begin
            padFull  <= 1'b0;
            wrPtr    <= '0;
            rdPtr    <= '0;
            count    <= '0;
            credits  <= '0;  // Consumer grants all credits
            resValid <= 1'b0;
        end else begin
            padFull  <= dbPinRe;
            resValid <= send;
            if (padFull) wrPtr <= nextPtr(wrPtr);
            if (send) rdPtr <= nextPtr(rdPtr);
            count   <= count + CNT_W'(padFull) - CNT_W'(send);
            credits <= credits + CNT_W'(resCredit) - CNT_W'(send);
        end
    end

    assert property (@(posedge lastT) disable iff (!rstN)
        credits <= CNT_W'(RES_DEPTH));

    // Sequencer honours resultSlotFree, so a buffered byte always finds room
    assert property (@(posedge lastT) disable iff (!rstN)
        padFull |-> (count < CNT_W'(RES_DEPTH)));

endmodule

`default_nettype wire

/* design/tStateSequencer.sv */
// Steps each machine cycle through its T-states, two lastT cycles per T-state
// Adds Tw states from WAIT and hands the bus to an outside master on BUSRQ
`timescale 1ns/1ps
`default_nettype none

module tStateSequencer (
    input  logic                 lastT,
    input  logic                 rstN,
    input  logic                 headValid,
    input  z80BusPkg::cycleKindT headKind,
    output logic                 headTake,
    input  logic                 resultSlotFree,
    input  logic                 waitPin,
    input  logic                 busrqPin,
    output z80BusPkg::cycleKindT curKind,
    output logic [2:0]           tState,
    output logic                 phaseLow,
    output logic                 waitState,
    output logic                 busGranted
);

    logic [2:0] finalT;     // Last T-state of the running kind
    logic [2:0] waitT;      // T-state whose end samples WAIT
    logic       boundary;   // Idle, or low half of the last T-state
    logic       headReady;  // Head may start now

    assign finalT   = z80BusPkg::lastTState(curKind);
    assign waitT    = z80BusPkg::waitTState(curKind);
    assign boundary = (tState == 3'd0) || ((tState == finalT) && phaseLow);

    // Read kinds need a free result slot before they start
    assign headReady = headValid &&
                       (!z80BusPkg::isReadKind(headKind) || resultSlotFree);

    // Start T1 next cycle unless the bus goes to the outside master
    assign headTake = boundary && headReady && !busGranted && !busrqPin;

    // --------------------
    // T-state and phase stepping
    always_ff @(posedge lastT or negedge rstN) begin
        if (!rstN) begin
            curKind    <= z80BusPkg::kFetch;
            tState     <= 3'd0;  // Idle
            phaseLow   <= 1'b0;
            waitState  <= 1'b0;
            busGranted <= 1'b0;
        end else begin
            // BUSRQ sampled at the cycle boundary, held until it drops
            if (busGranted || boundary) busGranted <= busrqPin;

            if (headTake) begin
                curKind   <= headKind;
                tState    <= 3'd1;
                phaseLow  <= 1'b0;
                waitState <= 1'b0;
            end else if (tState != 3'd0) begin
                phaseLow <= !phaseLow;
                if (phaseLow) begin  // End of a T-state
                    if (tState == finalT) begin
                        tState <= 3'd0;
                    end else if ((tState == waitT) && waitPin) begin
                        waitState <= 1'b1;  // Another Tw, tState stays put
                    end else begin
                        waitState <= 1'b0;
                        tState    <= tState + 3'd1;
                    end
                end
            end
        end
    end

    // --------------------
    // Checks
    assert property (@(posedge lastT) disable iff (!rstN)
        tState <= finalT);

    // Bus is never handed over in the middle of a cycle
    assert property (@(posedge lastT) disable iff (!rstN)
        busGranted |-> (tState == 3'd0));

endmodule

`default_nettype wire

/* design/z80BusPkg.sv */
// Shared types, widths and per-kind T-state tables of the bus-cycle engine
// Blocks reference these by scoped name
`default_nettype none

package z80BusPkg;

    localparam int ADDR_W = 16;  // Address bus width
    localparam int DATA_W = 8;   // Data bus width

    // Machine-cycle functions requested by the core
    typedef enum logic [2:0] {
        kFetch,
        kMemRead,
        kMemWrite,
        kIoRead,
        kIoWrite,
        kIntAck
    } cycleKindT;

    // Number of the final T-state of each kind
    function automatic logic [2:0] lastTState(input cycleKindT kind);
        case (kind)
            kMemRead, kMemWrite: return 3'd3;
            kIntAck:             return 3'd6;
            default:             return 3'd4;  // Fetch and both IO kinds
        endcase
    endfunction

    // T-state after which WAIT is sampled
    function automatic logic [2:0] waitTState(input cycleKindT kind);
        case (kind)
            kIoRead, kIoWrite: return 3'd3;
            kIntAck:           return 3'd4;
            default:           return 3'd2;  // Fetch and memory cycles
        endcase
    endfunction

    // Kinds that hand a data byte back to the core
    function automatic logic isReadKind(input cycleKindT kind);
        return (kind == kFetch) || (kind == kMemRead) ||
               (kind == kIoRead) || (kind == kIntAck);
    endfunction

endpackage

`default_nettype wire

/* design/z80BusUnit.sv */
// Top of the bus-cycle engine with queue, sequencer, pin decode and read return
// Holds the address and write data pad latches that drive the pins
`timescale 1ns/1ps
`default_nettype none

module z80BusUnit #(
    parameter int REQ_DEPTH = 4,
    parameter int RES_DEPTH = 2
) (
    input  logic                         lastT,
    input  logic                         rstN,
    // Core request side
    input  logic                         reqValid,
    input  z80BusPkg::cycleKindT         reqKind,
    input  logic [z80BusPkg::ADDR_W-1:0] reqAddr,
    input  logic [z80BusPkg::DATA_W-1:0] reqWrData,
    output logic                         reqCredit,
    // Consumer side
    input  logic                         resCredit,
    output logic                         resValid,
    output z80BusPkg::cycleKindT         resKind,
    output logic [z80BusPkg::DATA_W-1:0] resData,
    // Pins
    output logic                         m1,
    output logic                         mreq,
    output logic                         iorq,
    output logic                         rd,
    output logic                         wr,
    output logic                         rfsh,
    output logic                         busack,
    output logic [z80BusPkg::ADDR_W-1:0] addrPins,
    output logic                         addrPinOe,
    output logic [z80BusPkg::DATA_W-1:0] dataOut,
    output logic                         dataOutOe,
    output logic                         ctlPinOe,
    input  logic [z80BusPkg::DATA_W-1:0] dataIn,
    input  logic                         waitPin,
    input  logic                         busrqPin
);

    logic                         headValid, headTake;
    z80BusPkg::cycleKindT         headKind, curKind;
    logic [z80BusPkg::ADDR_W-1:0] headAddr, curAddr;       // curAddr is the running cycle's
    logic [z80BusPkg::DATA_W-1:0] headWrData, curWrData;
    logic [2:0]                   tState;
    logic                         phaseLow, waitState, busGranted;
    logic                         resultSlotFree;
    logic                         abWe, dbWe, dbPinRe;

    cycleRequestQueue #(.REQ_DEPTH(REQ_DEPTH)) uQueue (.*);

    tStateSequencer uSequencer (.*);

    pinControl uPins (.*);

    readDataReturn #(.RES_DEPTH(RES_DEPTH)) uReturn (.*);

    // --------------------
    // Internal bus values and pad latches
    always_ff @(posedge lastT) begin
        if (headTake) begin  // Head pops here, so keep a copy for the cycle
            curAddr   <= headAddr;
            curWrData <= headWrData;
        end
        if (abWe) addrPins <= curAddr;  // Refresh reuses the request address
        if (dbWe) dataOut <= curWrData;
    end

endmodule

`default_nettype wire

/* filelist.f */
design/z80BusPkg.sv
design/cycleRequestQueue.sv
design/tStateSequencer.sv
design/pinControl.sv
design/readDataReturn.sv
design/z80BusUnit.sv
bench/z80BusUnitTb.sv

/* run.sh */
#!/bin/sh
# Builds the bus-cycle engine testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
    --top-module z80BusUnitTb -f filelist.f -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation reported failure"
    exit $status
fi
exit 0
